// File: Bender.yml
package:
  name: tiny16

sources:
  - logic/tiny16_pkg.sv
  - logic/tiny16_decode.sv
  - logic/tiny16_alu.sv
  - logic/tiny16_core.sv
  - logic/tiny16_mem.sv
  - logic/tiny16_system.sv
  - target: test
    files:
      - tests/tiny16_clock_gen.sv
      - tests/tiny16_asserts.sv
      - tests/tiny16_tb.sv

// File: logic/tiny16_alu.sv
// tiny16 ALU, add, shifts by one and bitwise ops with carry out
module tiny16_alu (
    input  logic [tiny16_pkg::DATA_W-1:0] operand,
    input  logic [tiny16_pkg::DATA_W-1:0] imm,
    input  tiny16_pkg::alu_op_t           op,
    output logic [tiny16_pkg::DATA_W-1:0] result,
    output logic                          carry
);
    import tiny16_pkg::*;

    logic [DATA_W:0] sum;

    // one extra bit catches the carry
    assign sum = {1'b0, operand} + {1'b0, imm};

    always_comb begin
        result = operand;
        carry  = 1'b0;
        case (op)
            ALU_ADD: begin
                result = sum[DATA_W-1:0];
                carry  = sum[DATA_W];
            end
            ALU_SHL: begin
                // top bit falls out into carry
                result = {operand[DATA_W-2:0], 1'b0};
                carry  = operand[DATA_W-1];
            end
            ALU_SHR: begin
                // bottom bit falls out into carry
                result = {1'b0, operand[DATA_W-1:1]};
                carry  = operand[0];
            end
            ALU_XOR: begin
                result = operand ^ imm;
            end
            ALU_AND: begin
                result = operand & imm;
            end
            ALU_OR: begin
                result = operand | imm;
            end
            default: begin
                result = operand;
                carry  = 1'b0;
            end
        endcase
    end

endmodule

// File: logic/tiny16_core.sv
// tiny16 core with the four step stage ring, register file,
// accumulator, flags, program counter and memory strobes
module tiny16_core (
    input  logic                           clk,
    input  logic                           reset,
    output logic [tiny16_pkg::DATA_W-1:0]  address,
    input  logic [tiny16_pkg::DATA_W-1:0]  data_in,
    output logic [tiny16_pkg::DATA_W-1:0]  data_out,
    output logic                           rd_n,
    output logic                           wr_n,
    output logic                           hlt,
    output logic                           error,
    output logic [tiny16_pkg::STAGE_W-1:0] stage
);
    import tiny16_pkg::*;

    logic [DATA_W-1:0] regs [0:3];
    logic [DATA_W-1:0] instr;
    logic [DATA_W-1:0] acc;
    logic              carry;

    logic is_halt, is_br, is_jmp, is_mvi, is_load, is_store, is_movrr, is_alu;
    logic hi_byte, bad, cond_neg;
    alu_op_t alu_op;
    logic [1:0] src_reg, dst_reg;
    logic [2:0] cond_mask;
    logic [DATA_W-1:0] imm8, imm9, imm12;
    logic [7:0] byte_val;

    logic [DATA_W-1:0] alu_result;
    logic              alu_carry;
    logic              carry_upd;
    logic [2:0]        flags;
    logic              cond_pass;
    logic              go;

    // nop needs no action here
    tiny16_decode u_decode (
        .instruction (instr),
        .is_halt     (is_halt),
        .is_nop      (),
        .is_br       (is_br),
        .is_jmp      (is_jmp),
        .is_mvi      (is_mvi),
        .is_load     (is_load),
        .is_store    (is_store),
        .is_movrr    (is_movrr),
        .is_alu      (is_alu),
        .hi_byte     (hi_byte),
        .bad         (bad),
        .alu_op      (alu_op),
        .src_reg     (src_reg),
        .dst_reg     (dst_reg),
        .cond_mask   (cond_mask),
        .cond_neg    (cond_neg),
        .imm8        (imm8),
        .imm9        (imm9),
        .imm12       (imm12),
        .byte_val    (byte_val)
    );

    tiny16_alu u_alu (
        .operand (regs[src_reg]),
        .imm     (imm9),
        .op      (alu_op),
        .result  (alu_result),
        .carry   (alu_carry)
    );

    // mask bits select carry, zero, negative
    assign flags     = {carry, acc == '0, acc[DATA_W-1]};
    assign cond_pass = (|(cond_mask & flags)) ^ cond_neg;
    assign carry_upd = (alu_op == ALU_ADD) || (alu_op == ALU_SHL) || (alu_op == ALU_SHR);

    // core runs once out of reset until halted
    assign go = reset & !hlt;

    assign rd_n = !(go && (stage == STAGE_FETCH || (is_load && stage == STAGE_WB)));
    assign wr_n = !(go && is_store && stage == STAGE_WB);

    always_ff @(posedge clk) begin
        if (!reset) begin
            stage   <= STAGE_FETCH;
            instr   <= INSN_NOP;
            address <= '0;
            acc     <= '0;
            carry   <= 1'b0;
            hlt     <= 1'b0;
            error   <= 1'b0;
            for (int i = 0; i < 4; i++)
                regs[i] <= '0;
        end else if (go) begin
            stage <= {stage[STAGE_W-2:0], stage[STAGE_W-1]};
            case (stage)
                STAGE_FETCH: begin
                    instr <= data_in;
                end
                STAGE_EXEC: begin
                    hlt   <= is_halt | bad;
                    error <= bad;
                    if (is_jmp)
                        regs[REG_PC] <= regs[REG_PC] + imm12;
                    else if (is_br && cond_pass)
                        regs[REG_PC] <= regs[REG_PC] + imm8;
                    else
                        regs[REG_PC] <= regs[REG_PC] + 16'd1;
                    // load bases on src, store bases on dst
                    if (is_load || is_store)
                        address <= regs[is_load ? src_reg : dst_reg] + imm8;
                    if (is_store)
                        data_out <= regs[src_reg];
                    if (is_alu) begin
                        acc <= alu_result;
                        if (carry_upd)
                            carry <= alu_carry;
                    end
                end
                STAGE_WB: begin
                    if (is_load)
                        regs[dst_reg] <= data_in;
                    else if (is_movrr)
                        regs[dst_reg] <= regs[src_reg];
                    else if (is_mvi && hi_byte)
                        regs[src_reg][15:8] <= byte_val;
                    else if (is_mvi)
                        regs[src_reg][7:0] <= byte_val;
                    else if (is_alu)
                        regs[src_reg] <= acc;
                end
                STAGE_NEXT: begin
                    address <= regs[REG_PC];
                end
                default: begin
                    address <= address;
                end
            endcase
        end
    end

endmodule

// File: logic/tiny16_decode.sv
// instruction decoder for tiny16
// format match, register and condition fields, sign-extended immediates
module tiny16_decode (
    input  logic [tiny16_pkg::DATA_W-1:0] instruction,
    output logic                          is_halt,
    output logic                          is_nop,
    output logic                          is_br,
    output logic                          is_jmp,
    output logic                          is_mvi,
    output logic                          is_load,
    output logic                          is_store,
    output logic                          is_movrr,
    output logic                          is_alu,
    output logic                          hi_byte,
    output logic                          bad,
    output tiny16_pkg::alu_op_t           alu_op,
    output logic [1:0]                    src_reg,
    output logic [1:0]                    dst_reg,
    output logic [2:0]                    cond_mask,
    output logic                          cond_neg,
    output logic [tiny16_pkg::DATA_W-1:0] imm8,
    output logic [tiny16_pkg::DATA_W-1:0] imm9,
    output logic [tiny16_pkg::DATA_W-1:0] imm12,
    output logic [7:0]                    byte_val
);
    import tiny16_pkg::*;

    logic [3:0]  opcode;
    logic [4:0]  sub_op;
    logic [8:0]  field9;
    logic [11:0] field12;
    logic        is_adi;
    logic        is_shl;
    logic        is_shr;
    logic        is_xori;
    logic        is_andi;
    logic        is_ori;

    assign opcode  = instruction[7:4];
    assign sub_op  = instruction[7:3];
    assign field9  = {instruction[2], instruction[15:8]};
    assign field12 = {instruction[3:0], instruction[15:8]};

    assign byte_val  = instruction[15:8];
    assign src_reg   = instruction[1:0];
    assign dst_reg   = instruction[3:2];
    assign cond_mask = instruction[2:0];
    assign cond_neg  = instruction[3];
    assign hi_byte   = instruction[2];

    // whole word and shift codes
    assign is_halt = instruction == INSN_HALT;
    assign is_nop  = instruction == INSN_NOP;
    assign is_shr  = instruction[15:2] == SHR_CODE;
    assign is_shl  = instruction[15:2] == SHL_CODE;

    // nibble formats
    assign is_br    = opcode == OP_BR;
    assign is_jmp   = opcode == OP_JMP;
    assign is_load  = opcode == OP_MOVRM;
    assign is_store = opcode == OP_MOVMR;
    assign is_movrr = opcode == OP_MOVRR;

    // immediate formats
    assign is_mvi  = sub_op == SUB_MVI;
    assign is_adi  = sub_op == SUB_ADI;
    assign is_xori = sub_op == SUB_XORI;
    assign is_andi = sub_op == SUB_ANDI;
    assign is_ori  = sub_op == SUB_ORI;

    assign is_alu = is_adi | is_shl | is_shr | is_xori | is_andi | is_ori;

    // anything outside the known formats
    assign bad = !(is_halt | is_nop | is_br | is_jmp | is_mvi | is_load | is_store
                   | is_movrr | is_alu);

    always_comb begin
        alu_op = ALU_NONE;
        if (is_adi)
            alu_op = ALU_ADD;
        else if (is_shl)
            alu_op = ALU_SHL;
        else if (is_shr)
            alu_op = ALU_SHR;
        else if (is_xori)
            alu_op = ALU_XOR;
        else if (is_andi)
            alu_op = ALU_AND;
        else if (is_ori)
            alu_op = ALU_OR;
    end

    assign imm8  = {{8{byte_val[7]}}, byte_val};
    assign imm9  = {{7{field9[8]}}, field9};
    assign imm12 = {{4{field12[11]}}, field12};

endmodule

// File: logic/tiny16_mem.sv
// tiny16 word memory, core read and write port
// plus host load and peek port
module tiny16_mem (
    input  logic                          clk,
    input  logic [tiny16_pkg::DATA_W-1:0] address,
    input  logic [tiny16_pkg::DATA_W-1:0] data_in,
    output logic [tiny16_pkg::DATA_W-1:0] data_out,
    input  logic                          wr_n,
    input  logic                          load_en,
    input  logic [tiny16_pkg::MEM_AW-1:0] load_addr,
    input  logic [tiny16_pkg::DATA_W-1:0] load_data,
    input  logic [tiny16_pkg::MEM_AW-1:0] peek_addr,
    output logic [tiny16_pkg::DATA_W-1:0] peek_data
);
    import tiny16_pkg::*;

    logic [DATA_W-1:0] mem [0:(2**MEM_AW)-1];
    logic [MEM_AW-1:0] core_addr;

    // only the low address bits reach the array
    assign core_addr = address[MEM_AW-1:0];

    // core store wins over host load
    always_ff @(posedge clk) begin
        if (!wr_n)
            mem[core_addr] <= data_in;
        else if (load_en)
            mem[load_addr] <= load_data;
    end

    // both reads answer in the same cycle
    assign data_out  = mem[core_addr];
    assign peek_data = mem[peek_addr];

endmodule

// File: logic/tiny16_pkg.sv
// shared constants for the tiny16 processor
// register indices, stage codes, opcode fields and the ALU operation type
package tiny16_pkg;

    // word and memory sizes
    localparam int DATA_W = 16;
    localparam int MEM_AW = 8;

    // register file indices
    localparam logic [1:0] REG_A  = 2'd0;
    localparam logic [1:0] REG_W  = 2'd1;
    localparam logic [1:0] REG_X  = 2'd2;
    localparam logic [1:0] REG_PC = 2'd3;

    // one-hot stage ring, one clock per step
    localparam int STAGE_W = 4;
    localparam logic [STAGE_W-1:0] STAGE_FETCH = 4'b0001;
    localparam logic [STAGE_W-1:0] STAGE_EXEC  = 4'b0010;
    localparam logic [STAGE_W-1:0] STAGE_WB    = 4'b0100;
    localparam logic [STAGE_W-1:0] STAGE_NEXT  = 4'b1000;

    // upper nibble of the low byte selects the format
    // br     |offset,8|1|neg,mask3|
    // jmp    |offset,8|2|offset,4|
    // movrm  |offset,8|4|dst,2 src,2|  load, src is the base
    // movmr  |offset,8|5|dst,2 src,2|  store, dst is the base
    // movrr  |offset,8|6|dst,2 src,2|
    localparam logic [3:0] OP_BR    = 4'h1;
    localparam logic [3:0] OP_JMP   = 4'h2;
    localparam logic [3:0] OP_MOVRM = 4'h4;
    localparam logic [3:0] OP_MOVMR = 4'h5;
    localparam logic [3:0] OP_MOVRR = 4'h6;

    // five bit sub-opcode in bits 7:3, immediate bit 2, register 1:0
    // mvi uses bit 2 as the high byte select
    localparam logic [4:0] SUB_MVI  = 5'd6;
    localparam logic [4:0] SUB_ADI  = 5'd7;
    localparam logic [4:0] SUB_XORI = 5'd14;
    localparam logic [4:0] SUB_ANDI = 5'd15;
    localparam logic [4:0] SUB_ORI  = 5'd16;

    // whole word codes
    localparam logic [DATA_W-1:0] INSN_HALT = 16'h0000;
    localparam logic [DATA_W-1:0] INSN_NOP  = 16'h0001;

    // shifts by one, 14 bit code above the register field
    localparam logic [13:0] SHR_CODE = 14'd1;
    localparam logic [13:0] SHL_CODE = 14'd2;

    typedef enum logic [2:0] {
        ALU_NONE,
        ALU_ADD,
        ALU_SHL,
        ALU_SHR,
        ALU_XOR,
        ALU_AND,
        ALU_OR
    } alu_op_t;

endpackage

// File: logic/tiny16_system.sv
// tiny16 top level, core joined to the word memory
module tiny16_system (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          load_en,
    input  logic [tiny16_pkg::MEM_AW-1:0] load_addr,
    input  logic [tiny16_pkg::DATA_W-1:0] load_data,
    input  logic [tiny16_pkg::MEM_AW-1:0] peek_addr,
    output logic [tiny16_pkg::DATA_W-1:0] peek_data,
    output logic                          hlt,
    output logic                          error
);
    import tiny16_pkg::*;

    logic [DATA_W-1:0] address;
    logic [DATA_W-1:0] core_wdata;
    logic [DATA_W-1:0] core_rdata;
    logic              wr_n;

    // memory reads without a strobe, rd_n and stage stay inside the core
    tiny16_core u_core (
        .clk      (clk),
        .reset    (reset),
        .address  (address),
        .data_in  (core_rdata),
        .data_out (core_wdata),
        .rd_n     (),
        .wr_n     (wr_n),
        .hlt      (hlt),
        .error    (error),
        .stage    ()
    );

    tiny16_mem u_mem (
        .clk       (clk),
        .address   (address),
        .data_in   (core_wdata),
        .data_out  (core_rdata),
        .wr_n      (wr_n),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .peek_addr (peek_addr),
        .peek_data (peek_data)
    );

endmodule

// File: tests/tiny16_asserts.sv
// concurrent checks on the tiny16 core stage ring and memory strobes
// bound to every instance of the core
module tiny16_asserts (
    input logic                           clk,
    input logic                           reset,
    input logic [tiny16_pkg::STAGE_W-1:0] stage,
    input logic                           rd_n,
    input logic                           wr_n,
    input logic                           hlt
);
    // exactly one step active once out of reset
    stage_one_hot: assert property (@(posedge clk) disable iff (!reset) $onehot(stage))
        else $error("stage ring is not one-hot");

    // read and write strobes exclude each other
    strobes_exclusive: assert property (@(posedge clk) !(!rd_n && !wr_n))
        else $error("rd_n and wr_n are low together");

    // a halted core leaves memory alone
    quiet_when_halted: assert property (@(posedge clk) hlt |-> (rd_n && wr_n))
        else $error("memory strobe active while halted");

endmodule

bind tiny16_core tiny16_asserts u_asserts (
    .clk   (clk),
    .reset (reset),
    .stage (stage),
    .rd_n  (rd_n),
    .wr_n  (wr_n),
    .hlt   (hlt)
);

// File: tests/tiny16_clock_gen.sv
// free running clock for the tiny16 testbench
module tiny16_clock_gen (
    output logic clk
);
    localparam int HALF_PERIOD = 4;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

endmodule

// File: tests/tiny16_tb.sv
// testbench for the tiny16 system
// program table, host loader, run loop, result checks and watchdog
module tiny16_tb;
    import tiny16_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 4;
    localparam int NUM_ROWS     = 6;
    localparam int PROG_LEN     = 16;
    localparam int FILL_BASE    = 128;
    localparam int FILL_WORDS   = 128;
    // four cycles per instruction, plus reset, loading and fill
    localparam int WATCHDOG_CYCLES = 4 * PROG_LEN * NUM_ROWS
                                   + NUM_ROWS * (RESET_CYCLES + PROG_LEN + 4)
                                   + FILL_WORDS + 100;

    logic              clk;
    logic              reset;
    logic              load_en;
    logic [MEM_AW-1:0] load_addr;
    logic [DATA_W-1:0] load_data;
    logic [MEM_AW-1:0] peek_addr;
    logic [DATA_W-1:0] peek_data;
    logic              hlt;
    logic              error;
    integer            seed;

    logic [DATA_W-1:0] fill_words [0:(2**MEM_AW)-1];

    // one row per program, registers A=0 W=1 X=2 PC=3
    logic [DATA_W-1:0] prog_table [0:NUM_ROWS-1][0:PROG_LEN-1] = '{
        // mvi lo A,90; mvi hi W,BE; mvi lo W,EF; st [A],W; halt
        '{16'h9030, 16'hBE35, 16'hEF31, 16'h0051, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
          16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
        // W=F000; adi W,-256; bc +2; ori W,10; xori FF; andi -16; ori A; shl; shr; st
        '{16'h9130, 16'hF035, 16'h003D, 16'h0214, 16'h1081, 16'hFF71, 16'hF07D, 16'h0A81,
          16'h0009, 16'h0005, 16'h0051, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
        // xori W,0; bnz +7 not taken; bnn +2 taken; W=55AA; st; wrong path at 9
        '{16'h9230, 16'h0071, 16'h071A, 16'h0219, 16'h00FF, 16'h5535, 16'hAA31, 16'h0051,
          16'h0000, 16'h1131, 16'h0051, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
        // A=A8; ld W,[A-8]; mov X,W; st [A+8],X; halt
        '{16'hA830, 16'hF844, 16'h0069, 16'h0852, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
          16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
        // call: mov X,PC; adi X,4; st [A],X; jmp +5. return at 6, subroutine at 9
        '{16'hC030, 16'h006B, 16'h043A, 16'h0052, 16'h0520, 16'h00FF, 16'h1235, 16'h0151,
          16'h0000, 16'h3431, 16'h004C, 16'h00FF, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
        // undefined word before the store
        '{16'hD030, 16'h7731, 16'h00FF, 16'h0051, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
          16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000}
    };
    logic [MEM_AW-1:0] result_addr   [0:NUM_ROWS-1] = '{8'h90, 8'h91, 8'h92, 8'hB0, 8'hC1, 8'hD0};
    logic [DATA_W-1:0] expected_word [0:NUM_ROWS-1] = '{16'hBEEF, 16'h6FFA, 16'h55AA,
                                                         16'h0000, 16'h1234, 16'h0000};
    logic              expected_err  [0:NUM_ROWS-1] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};

    tiny16_clock_gen u_clock (
        .clk (clk)
    );

    tiny16_system u_dut (
        .clk       (clk),
        .reset     (reset),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .peek_addr (peek_addr),
        .peek_data (peek_data),
        .hlt       (hlt),
        .error     (error)
    );

    task automatic check_value(input string name, input logic [DATA_W-1:0] actual,
                               input logic [DATA_W-1:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH time=%0t signal=%s actual=%h expected=%h",
                     $time, name, actual, expected);
            $display("Errors found");
            $fatal(1, "value check failed");
        end
    endtask

    // random words in the upper half, loaded while reset is low
    task automatic fill_data_area();
        for (int a = FILL_BASE; a < FILL_BASE + FILL_WORDS; a++) begin
            fill_words[a] = DATA_W'($random(seed));
            load_en   = 1'b1;
            load_addr = a[MEM_AW-1:0];
            load_data = fill_words[a];
            @(negedge clk);
        end
        load_en = 1'b0;
    endtask

    task automatic run_program(input int row);
        reset = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        for (int i = 0; i < PROG_LEN; i++) begin
            load_en   = 1'b1;
            load_addr = i[MEM_AW-1:0];
            load_data = prog_table[row][i];
            @(negedge clk);
        end
        load_en = 1'b0;
        reset   = 1'b1;
        while (hlt !== 1'b1)
            @(negedge clk);
        peek_addr = result_addr[row];
        @(negedge clk);
        check_value($sformatf("peek_data row %0d", row), peek_data, expected_word[row]);
        check_value($sformatf("error row %0d", row), {15'b0, error}, {15'b0, expected_err[row]});
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the processor never halted within %0d cycles", WATCHDOG_CYCLES);
        $display("Errors found");
        $fatal(1, "watchdog expired");
    end

    initial begin
        reset     = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        peek_addr = '0;
        seed      = 37;
        repeat (RESET_CYCLES) @(negedge clk);
        fill_data_area();
        // copy row reads the source word, error row leaves its target untouched
        expected_word[3] = fill_words[8'hA0];
        expected_word[5] = fill_words[8'hD0];
        for (int r = 0; r < NUM_ROWS; r++)
            run_program(r);
        $display("No errors");
        $finish;
    end

endmodule

// File: vlog.f
logic/tiny16_pkg.sv
logic/tiny16_decode.sv
logic/tiny16_alu.sv
logic/tiny16_core.sv
logic/tiny16_mem.sv
logic/tiny16_system.sv
tests/tiny16_clock_gen.sv
tests/tiny16_asserts.sv
tests/tiny16_tb.sv
